// File: list.f
src/core_pkg.sv
src/exc_pkg.sv
src/wb_lane_if.sv
src/ex2_result_select.sv
src/exception_commit.sv
src/wb_stage_reg.sv
src/regfile_writeback.sv
src/ex2_wb_top.sv
tb/tb_ex2_wb.sv

// File: run.sh
#!/bin/sh
# build and run the testbench with Verilator, pass is decided from the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f list.f --top-module tb_ex2_wb -o tb_ex2_wb

./obj_dir/tb_ex2_wb > sim.log
cat sim.log

grep -q -F "*** TEST PASSED ***" sim.log
echo "simulation passed"

// File: src/core_pkg.sv
package core_pkg;

    // datapath widths
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    // uop is a small one-hot style flag vector from decode
    localparam int uop_w = 8;

    // bit positions inside the uop
    localparam int uop_alu  = 0;
    localparam int uop_mem  = 1;
    localparam int uop_csr  = 2;
    // branch-and-link, result needs pc+4 correction
    localparam int uop_link = 3;

    // andi r0, r0, 0
    localparam logic [31:0] inst_nop = 32'h0340_0000;

    // one writeback lane as it moves between the stages
    typedef struct packed {
        logic                  we;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       data;
        logic [xlen-1:0]       pc;
        logic [31:0]           inst;
    } wb_lane_t;

endpackage

// File: src/ex2_result_select.sv
`timescale 1ns/1ns

module ex2_result_select
    import core_pkg::*;
(
    input  logic [uop_w-1:0]      uop0,
    input  logic [uop_w-1:0]      uop1,
    input  logic [xlen-1:0]       alu_result0,
    input  logic [xlen-1:0]       alu_result1,
    input  logic                  alu_valid0,
    input  logic                  alu_valid1,
    input  logic [reg_addr_w-1:0] rd0,
    input  logic [reg_addr_w-1:0] rd1,
    input  logic [xlen-1:0]       pc0,
    input  logic [xlen-1:0]       pc1,
    input  logic [31:0]           inst0,
    input  logic [31:0]           inst1,
    input  logic [xlen-1:0]       dcache_data,
    input  logic                  dcache_ready,
    input  logic [xlen-1:0]       csr_rdata,
    input  logic                  exc_valid,
    input  logic                  interrupt,
    output logic                  allowin,
    wb_lane_if.src                lane0,
    wb_lane_if.src                lane1
);

    wb_lane_t sel0;
    wb_lane_t sel1;
    logic     hit0;
    logic     kill;

    // load waiting on the cache holds the whole slice
    assign allowin = !(uop0[uop_mem] && !dcache_ready);

    // nothing retires under an exception, interrupt or stall
    assign kill = exc_valid || interrupt || !allowin;

    // lane 0 source priority: alu, load, csr
    always_comb begin
        hit0      = 1'b1;
        sel0.data = '0;
        if (alu_valid0) begin
            // link register holds the return address
            sel0.data = uop0[uop_link] ? alu_result0 + xlen'(4) : alu_result0;
        end else if (uop0[uop_mem] && dcache_ready) begin
            sel0.data = dcache_data;
        end else if (uop0[uop_csr]) begin
            sel0.data = csr_rdata;
        end else begin
            hit0 = 1'b0;
        end
        // r0 writes are dropped here so later stages never see them
        sel0.we   = hit0 && (rd0 != '0) && !kill;
        sel0.rd   = rd0;
        sel0.pc   = pc0;
        sel0.inst = inst0;
    end

    // lane 1 is alu only
    always_comb begin
        sel1.we   = alu_valid1 && uop1[uop_alu] && (rd1 != '0) && !kill;
        sel1.rd   = rd1;
        sel1.data = alu_result1;
        sel1.pc   = pc1;
        sel1.inst = inst1;
    end

    assign lane0.lane = sel0;
    assign lane1.lane = sel1;

endmodule

// File: src/ex2_wb_top.sv
`timescale 1ns/1ns

module ex2_wb_top
    import core_pkg::*;
    import exc_pkg::*;
#(
    parameter int num_regs = 32,
    parameter int vppn_w   = 19
) (
    input  logic                  clk,
    input  logic                  aresetn,
    // issue side
    input  logic [uop_w-1:0]      uop0,
    input  logic [uop_w-1:0]      uop1,
    input  logic [xlen-1:0]       alu_result0,
    input  logic [xlen-1:0]       alu_result1,
    input  logic                  alu_valid0,
    input  logic                  alu_valid1,
    input  logic [reg_addr_w-1:0] rd0,
    input  logic [reg_addr_w-1:0] rd1,
    input  logic [xlen-1:0]       pc0,
    input  logic [xlen-1:0]       pc1,
    input  logic [31:0]           inst0,
    input  logic [31:0]           inst1,
    input  logic [xlen-1:0]       dcache_data,
    input  logic                  dcache_ready,
    input  logic [xlen-1:0]       csr_rdata,
    // exception side
    input  logic                  exc_valid,
    input  logic [ecode_w-1:0]    ecode,
    input  logic [xlen-1:0]       badv,
    input  logic                  interrupt,
    input  logic [xlen-1:0]       eentry,
    input  logic [xlen-1:0]       tlbrentry,
    output logic                  allowin,
    output logic                  flush,
    output logic [ecode_w-1:0]    ecode_out,
    output logic [xlen-1:0]       era_out,
    output logic                  wen_era,
    output logic [xlen-1:0]       badv_out,
    output logic                  wen_badv,
    output logic [vppn_w-1:0]     vppn_out,
    output logic                  wen_vppn,
    output logic                  tlb_refill,
    output logic [xlen-1:0]       redirect_pc,
    // register file read port
    input  logic [reg_addr_w-1:0] raddr,
    output logic [xlen-1:0]       rdata,
    // trace port
    output logic [xlen-1:0]       trace0_pc,
    output logic [31:0]           trace0_inst,
    output logic                  trace0_we,
    output logic [reg_addr_w-1:0] trace0_rd,
    output logic [xlen-1:0]       trace0_data,
    output logic [xlen-1:0]       trace1_pc,
    output logic [31:0]           trace1_inst,
    output logic                  trace1_we,
    output logic [reg_addr_w-1:0] trace1_rd,
    output logic [xlen-1:0]       trace1_data,
    output logic                  trace_valid
);

    // select to register, register to regfile
    wb_lane_if sel_lane0 ();
    wb_lane_if sel_lane1 ();
    wb_lane_if wb_lane0 ();
    wb_lane_if wb_lane1 ();

    ex2_result_select ex2_result_select_inst (
        .uop0         (uop0),
        .uop1         (uop1),
        .alu_result0  (alu_result0),
        .alu_result1  (alu_result1),
        .alu_valid0   (alu_valid0),
        .alu_valid1   (alu_valid1),
        .rd0          (rd0),
        .rd1          (rd1),
        .pc0          (pc0),
        .pc1          (pc1),
        .inst0        (inst0),
        .inst1        (inst1),
        .dcache_data  (dcache_data),
        .dcache_ready (dcache_ready),
        .csr_rdata    (csr_rdata),
        .exc_valid    (exc_valid),
        .interrupt    (interrupt),
        .allowin      (allowin),
        .lane0        (sel_lane0.src),
        .lane1        (sel_lane1.src)
    );

    exception_commit #(
        .vppn_w (vppn_w)
    ) exception_commit_inst (
        .clk         (clk),
        .aresetn     (aresetn),
        .exc_valid   (exc_valid),
        .ecode       (ecode),
        .badv        (badv),
        .pc0         (pc0),
        .interrupt   (interrupt),
        .eentry      (eentry),
        .tlbrentry   (tlbrentry),
        .flush       (flush),
        .ecode_out   (ecode_out),
        .era_out     (era_out),
        .wen_era     (wen_era),
        .badv_out    (badv_out),
        .wen_badv    (wen_badv),
        .vppn_out    (vppn_out),
        .wen_vppn    (wen_vppn),
        .tlb_refill  (tlb_refill),
        .redirect_pc (redirect_pc)
    );

    wb_stage_reg wb_stage_reg_inst (
        .clk         (clk),
        .aresetn     (aresetn),
        .flush       (flush),
        .allowin     (allowin),
        .in0         (sel_lane0.dst),
        .in1         (sel_lane1.dst),
        .out0        (wb_lane0.src),
        .out1        (wb_lane1.src),
        .trace_valid (trace_valid)
    );

    regfile_writeback #(
        .num_regs (num_regs)
    ) regfile_writeback_inst (
        .clk     (clk),
        .aresetn (aresetn),
        .lane0   (wb_lane0.dst),
        .lane1   (wb_lane1.dst),
        .raddr   (raddr),
        .rdata   (rdata)
    );

    // trace mirrors the writeback register, one edge ahead of the regfile
    assign trace0_pc   = wb_lane0.lane.pc;
    assign trace0_inst = wb_lane0.lane.inst;
    assign trace0_we   = wb_lane0.lane.we;
    assign trace0_rd   = wb_lane0.lane.rd;
    assign trace0_data = wb_lane0.lane.data;
    assign trace1_pc   = wb_lane1.lane.pc;
    assign trace1_inst = wb_lane1.lane.inst;
    assign trace1_we   = wb_lane1.lane.we;
    assign trace1_rd   = wb_lane1.lane.rd;
    assign trace1_data = wb_lane1.lane.data;

endmodule

// File: src/exc_pkg.sv
package exc_pkg;

    localparam int ecode_w = 6;

    // loongarch ecode values
    localparam logic [ecode_w-1:0] exc_int  = 6'h00;
    localparam logic [ecode_w-1:0] exc_pil  = 6'h01;
    localparam logic [ecode_w-1:0] exc_pis  = 6'h02;
    localparam logic [ecode_w-1:0] exc_pif  = 6'h03;
    localparam logic [ecode_w-1:0] exc_pme  = 6'h04;
    localparam logic [ecode_w-1:0] exc_ppi  = 6'h07;
    localparam logic [ecode_w-1:0] exc_adef = 6'h08;
    localparam logic [ecode_w-1:0] exc_ale  = 6'h09;
    localparam logic [ecode_w-1:0] exc_tlbr = 6'h3f;

    // address related faults, badv gets the faulting address
    function automatic logic sets_badv(input logic [ecode_w-1:0] code);
        return (code == exc_pil) || (code == exc_pis) || (code == exc_pif)
            || (code == exc_pme) || (code == exc_ppi) || (code == exc_adef)
            || (code == exc_ale) || (code == exc_tlbr);
    endfunction

    // tlb related faults only, ale and adef leave tlbehi alone
    function automatic logic sets_vppn(input logic [ecode_w-1:0] code);
        return (code == exc_pil) || (code == exc_pis) || (code == exc_pif)
            || (code == exc_pme) || (code == exc_ppi) || (code == exc_tlbr);
    endfunction

endpackage

// File: src/exception_commit.sv
`timescale 1ns/1ns

module exception_commit
    import core_pkg::*;
    import exc_pkg::*;
#(
    parameter int vppn_w = 19
) (
    input  logic               clk,
    input  logic               aresetn,
    input  logic               exc_valid,
    input  logic [ecode_w-1:0] ecode,
    input  logic [xlen-1:0]    badv,
    input  logic [xlen-1:0]    pc0,
    input  logic               interrupt,
    input  logic [xlen-1:0]    eentry,
    input  logic [xlen-1:0]    tlbrentry,
    output logic               flush,
    output logic [ecode_w-1:0] ecode_out,
    output logic [xlen-1:0]    era_out,
    output logic               wen_era,
    output logic [xlen-1:0]    badv_out,
    output logic               wen_badv,
    output logic [vppn_w-1:0]  vppn_out,
    output logic               wen_vppn,
    output logic               tlb_refill,
    output logic [xlen-1:0]    redirect_pc
);

    logic               take;
    logic [ecode_w-1:0] code;

    assign take = exc_valid || interrupt;
    // a synchronous exception outranks a pending interrupt
    assign code = exc_valid ? ecode : exc_int;

    // strobes are one cycle pulses after the event edge
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            flush      <= 1'b0;
            wen_era    <= 1'b0;
            wen_badv   <= 1'b0;
            wen_vppn   <= 1'b0;
            tlb_refill <= 1'b0;
        end else begin
            flush      <= take;
            wen_era    <= take;
            wen_badv   <= exc_valid && sets_badv(ecode);
            wen_vppn   <= exc_valid && sets_vppn(ecode);
            tlb_refill <= exc_valid && (ecode == exc_tlbr);
        end
    end

    // csr payload, only meaningful while its strobe is up
    always_ff @(posedge clk) begin
        if (take) begin
            ecode_out <= code;
            era_out   <= pc0;
            badv_out  <= badv;
            // vppn is the top of the bad address
            vppn_out  <= badv[xlen-1 -: vppn_w];
        end
    end

    // refill has its own vector
    assign redirect_pc = tlb_refill ? tlbrentry : eentry;

endmodule

// File: src/regfile_writeback.sv
`timescale 1ns/1ns

module regfile_writeback
    import core_pkg::*;
#(
    parameter int num_regs = 32
) (
    input  logic                  clk,
    input  logic                  aresetn,
    wb_lane_if.dst                lane0,
    wb_lane_if.dst                lane1,
    input  logic [reg_addr_w-1:0] raddr,
    output logic [xlen-1:0]       rdata
);

    logic [xlen-1:0] regs [num_regs];
    logic            wr0;
    logic            wr1;

    // no writes while reset is held
    assign wr0 = aresetn && lane0.lane.we && (lane0.lane.rd != '0);
    assign wr1 = aresetn && lane1.lane.we && (lane1.lane.rd != '0);

    // lane 1 is the younger instruction
    // its write comes last and wins on the same rd
    always_ff @(posedge clk) begin
        if (wr0) begin
            regs[lane0.lane.rd] <= lane0.lane.data;
        end
        if (wr1) begin
            regs[lane1.lane.rd] <= lane1.lane.data;
        end
    end

    // r0 is hardwired zero
    assign rdata = (raddr == '0) ? '0 : regs[raddr];

endmodule

// File: src/wb_lane_if.sv
`timescale 1ns/1ns

// one writeback lane record between stages
interface wb_lane_if
    import core_pkg::*;
();

    wb_lane_t lane;

    // producing side
    modport src (
        output lane
    );

    // consuming side
    modport dst (
        input lane
    );

endinterface

// File: src/wb_stage_reg.sv
`timescale 1ns/1ns

module wb_stage_reg
    import core_pkg::*;
(
    input  logic   clk,
    input  logic   aresetn,
    input  logic   flush,
    input  logic   allowin,
    wb_lane_if.dst in0,
    wb_lane_if.dst in1,
    wb_lane_if.src out0,
    wb_lane_if.src out1,
    output logic   trace_valid
);

    wb_lane_t lane0_q;
    wb_lane_t lane1_q;

    always_ff @(posedge clk) begin
        if (!aresetn || flush) begin
            // empty stage, trace shows a nop
            lane0_q      <= '0;
            lane1_q      <= '0;
            lane0_q.inst <= inst_nop;
            lane1_q.inst <= inst_nop;
            trace_valid  <= 1'b0;
        end else if (!allowin) begin
            // bubble while the load waits
            // pc and inst stay for the trace
            lane0_q.we  <= 1'b0;
            lane1_q.we  <= 1'b0;
            trace_valid <= 1'b0;
        end else begin
            lane0_q     <= in0.lane;
            lane1_q     <= in1.lane;
            trace_valid <= 1'b1;
        end
    end

    assign out0.lane = lane0_q;
    assign out1.lane = lane1_q;

endmodule

// File: tb/tb_ex2_wb.sv
`timescale 1ns/1ns

module tb_ex2_wb
    import core_pkg::*;
    import exc_pkg::*;
();

    localparam logic [31:0] eentry_addr    = 32'h1c00_8000;
    localparam logic [31:0] tlbrentry_addr = 32'h1c00_f000;

    // one table row: inputs of a dual issue group plus expected strobes
    typedef struct packed {
        logic [uop_w-1:0]      uop0;
        logic [uop_w-1:0]      uop1;
        logic                  alu_valid0;
        logic                  alu_valid1;
        logic [31:0]           alu_result0;
        logic [31:0]           alu_result1;
        logic [reg_addr_w-1:0] rd0;
        logic [reg_addr_w-1:0] rd1;
        logic [31:0]           pc0;
        logic [31:0]           pc1;
        logic [31:0]           inst0;
        logic [31:0]           inst1;
        logic [31:0]           dcache_data;
        logic [31:0]           csr_rdata;
        logic [7:0]            stall_cycles;
        logic                  exc_valid;
        logic [ecode_w-1:0]    ecode;
        logic [31:0]           badv;
        logic                  interrupt;
        logic                  exp_flush;
        logic                  exp_badv;
        logic                  exp_vppn;
        logic                  exp_refill;
    } row_t;

    logic clk;
    logic aresetn;
    logic [uop_w-1:0] uop0;
    logic [uop_w-1:0] uop1;
    logic [31:0] alu_result0;
    logic [31:0] alu_result1;
    logic alu_valid0;
    logic alu_valid1;
    logic [reg_addr_w-1:0] rd0;
    logic [reg_addr_w-1:0] rd1;
    logic [31:0] pc0;
    logic [31:0] pc1;
    logic [31:0] inst0;
    logic [31:0] inst1;
    logic [31:0] dcache_data;
    logic dcache_ready;
    logic [31:0] csr_rdata;
    logic exc_valid;
    logic [ecode_w-1:0] ecode;
    logic [31:0] badv;
    logic interrupt;
    logic [31:0] eentry;
    logic [31:0] tlbrentry;
    logic allowin;
    logic flush;
    logic [ecode_w-1:0] ecode_out;
    logic [31:0] era_out;
    logic wen_era;
    logic [31:0] badv_out;
    logic wen_badv;
    logic [18:0] vppn_out;
    logic wen_vppn;
    logic tlb_refill;
    logic [31:0] redirect_pc;
    logic [reg_addr_w-1:0] raddr;
    logic [31:0] rdata;
    logic [31:0] trace0_pc;
    logic [31:0] trace0_inst;
    logic trace0_we;
    logic [reg_addr_w-1:0] trace0_rd;
    logic [31:0] trace0_data;
    logic [31:0] trace1_pc;
    logic [31:0] trace1_inst;
    logic trace1_we;
    logic [reg_addr_w-1:0] trace1_rd;
    logic [31:0] trace1_data;
    logic trace_valid;

    // reference register file and which entries hold a defined value
    logic [31:0] model_regs [32];
    logic        known [32];
    row_t        rows [$];
    int          checks;
    int          errors;

    ex2_wb_top ex2_wb_top_inst (.*);

    always #2 clk = ~clk;

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR t=%0t %s: got %h expected %h", $time, name, actual, expected);
        end
    endtask

    function automatic logic [uop_w-1:0] uop_bit(input int pos);
        logic [uop_w-1:0] v;
        v      = '0;
        v[pos] = 1'b1;
        return v;
    endfunction

    // default row, both lanes alu with random data
    function automatic row_t new_row(input logic [reg_addr_w-1:0] a0,
                                     input logic [reg_addr_w-1:0] a1);
        row_t r;
        r             = '0;
        r.uop0        = uop_bit(uop_alu);
        r.uop1        = uop_bit(uop_alu);
        r.alu_valid0  = 1'b1;
        r.alu_valid1  = 1'b1;
        r.alu_result0 = $urandom();
        r.alu_result1 = $urandom();
        r.rd0         = a0;
        r.rd1         = a1;
        r.pc0         = $urandom() & 32'hffff_fffc;
        r.pc1         = r.pc0 + 32'd4;
        r.inst0       = $urandom();
        r.inst1       = $urandom();
        r.dcache_data = $urandom();
        r.csr_rdata   = $urandom();
        r.badv        = $urandom();
        return r;
    endfunction

    task automatic build_table();
        row_t r;
        // dual alu, then r0 on lane 0
        rows.push_back(new_row(5'd1, 5'd2));
        rows.push_back(new_row(5'd0, 5'd3));
        // branch and link on lane 0
        r      = new_row(5'd4, 5'd5);
        r.uop0 = uop_bit(uop_alu) | uop_bit(uop_link);
        rows.push_back(r);
        // csr read, lane 1 idle
        r            = new_row(5'd6, 5'd0);
        r.uop0       = uop_bit(uop_csr);
        r.alu_valid0 = 1'b0;
        r.alu_valid1 = 1'b0;
        rows.push_back(r);
        // load that misses for three cycles
        r              = new_row(5'd7, 5'd8);
        r.uop0         = uop_bit(uop_mem);
        r.alu_valid0   = 1'b0;
        r.stall_cycles = 8'd3;
        rows.push_back(r);
        // same rd on both lanes
        rows.push_back(new_row(5'd9, 5'd9));
        // ale: badv but no vppn
        r           = new_row(5'd1, 5'd2);
        r.exc_valid = 1'b1;
        r.ecode     = exc_ale;
        r.exp_flush = 1'b1;
        r.exp_badv  = 1'b1;
        rows.push_back(r);
        // tlb refill
        r            = new_row(5'd3, 5'd4);
        r.exc_valid  = 1'b1;
        r.ecode      = exc_tlbr;
        r.exp_flush  = 1'b1;
        r.exp_badv   = 1'b1;
        r.exp_vppn   = 1'b1;
        r.exp_refill = 1'b1;
        rows.push_back(r);
        // interrupt with no exception, stale ecode on the bus
        r           = new_row(5'd5, 5'd6);
        r.interrupt = 1'b1;
        r.ecode     = exc_pil;
        r.exp_flush = 1'b1;
        rows.push_back(r);
        // normal retire after the flushes, over registers already known
        rows.push_back(new_row(5'd1, 5'd9));
    endtask

    // expected lane writes from the result selection rules
    task automatic predict(input row_t r, output logic we0, output logic [31:0] d0,
                           output logic we1, output logic [31:0] d1);
        logic hit;
        logic blocked;
        blocked = r.exc_valid || r.interrupt;
        hit     = 1'b1;
        d0      = '0;
        if (r.alu_valid0) begin
            d0 = r.uop0[uop_link] ? r.alu_result0 + 32'd4 : r.alu_result0;
        end else if (r.uop0[uop_mem]) begin
            // cache is ready by the time the load retires
            d0 = r.dcache_data;
        end else if (r.uop0[uop_csr]) begin
            d0 = r.csr_rdata;
        end else begin
            hit = 1'b0;
        end
        we0 = hit && (r.rd0 != '0) && !blocked;
        we1 = r.alu_valid1 && (r.rd1 != '0) && !blocked;
        d1  = r.alu_result1;
    endtask

    task automatic drive_idle();
        uop0         = '0;
        uop1         = '0;
        alu_result0  = '0;
        alu_result1  = '0;
        alu_valid0   = 1'b0;
        alu_valid1   = 1'b0;
        rd0          = '0;
        rd1          = '0;
        pc0          = '0;
        pc1          = '0;
        inst0        = '0;
        inst1        = '0;
        dcache_data  = '0;
        dcache_ready = 1'b1;
        csr_rdata    = '0;
        exc_valid    = 1'b0;
        ecode        = '0;
        badv         = '0;
        interrupt    = 1'b0;
    endtask

    task automatic drive_row(input row_t r);
        uop0         = r.uop0;
        uop1         = r.uop1;
        alu_result0  = r.alu_result0;
        alu_result1  = r.alu_result1;
        alu_valid0   = r.alu_valid0;
        alu_valid1   = r.alu_valid1;
        rd0          = r.rd0;
        rd1          = r.rd1;
        pc0          = r.pc0;
        pc1          = r.pc1;
        inst0        = r.inst0;
        inst1        = r.inst1;
        dcache_data  = r.dcache_data;
        dcache_ready = (r.stall_cycles == '0);
        csr_rdata    = r.csr_rdata;
        exc_valid    = r.exc_valid;
        ecode        = r.ecode;
        badv         = r.badv;
        interrupt    = r.interrupt;
    endtask

    task automatic wait_allowin();
        int cnt;
        cnt = 0;
        while (!allowin && cnt < 20) begin
            @(posedge clk);
            #1;
            cnt++;
        end
        if (!allowin) begin
            errors++;
            $display("timeout: allowin stayed low after the data cache became ready");
        end
    endtask

    // read port is combinational, settles within the same cycle
    task automatic read_back(input logic [reg_addr_w-1:0] a);
        raddr = a;
        #1;
        if (known[a]) begin
            check($sformatf("rdata[r%0d]", a), rdata, model_regs[a]);
        end
    endtask

    task automatic run_row(input row_t r);
        logic        we0;
        logic [31:0] d0;
        logic        we1;
        logic [31:0] d1;
        logic [31:0] held_pc;
        predict(r, we0, d0, we1, d1);
        @(posedge clk);
        #1;
        drive_row(r);
        #1;
        check("allowin", 32'(allowin), 32'(r.stall_cycles == '0));
        held_pc = trace0_pc;
        // bubbles while the load waits
        for (int s = 0; s < int'(r.stall_cycles); s++) begin
            @(posedge clk);
            #1;
            check("allowin", 32'(allowin), 32'(1'b0));
            check("trace_valid", 32'(trace_valid), 32'(1'b0));
            check("trace0_we", 32'(trace0_we), 32'(1'b0));
            check("trace1_we", 32'(trace1_we), 32'(1'b0));
            check("trace0_pc", trace0_pc, held_pc);
        end
        if (r.stall_cycles != '0) begin
            dcache_ready = 1'b1;
            #1;
            wait_allowin();
        end
        // edge N, the writeback register takes the group
        @(posedge clk);
        #1;
        check("trace_valid", 32'(trace_valid), 32'(1'b1));
        check("trace0_we", 32'(trace0_we), 32'(we0));
        check("trace0_pc", trace0_pc, r.pc0);
        check("trace0_inst", trace0_inst, r.inst0);
        check("trace1_we", 32'(trace1_we), 32'(we1));
        check("trace1_pc", trace1_pc, r.pc1);
        check("trace1_inst", trace1_inst, r.inst1);
        if (we0) begin
            check("trace0_rd", 32'(trace0_rd), 32'(r.rd0));
            check("trace0_data", trace0_data, d0);
        end
        if (we1) begin
            check("trace1_rd", 32'(trace1_rd), 32'(r.rd1));
            check("trace1_data", trace1_data, d1);
        end
        check("flush", 32'(flush), 32'(r.exp_flush));
        check("wen_era", 32'(wen_era), 32'(r.exp_flush));
        check("wen_badv", 32'(wen_badv), 32'(r.exp_badv));
        check("wen_vppn", 32'(wen_vppn), 32'(r.exp_vppn));
        check("tlb_refill", 32'(tlb_refill), 32'(r.exp_refill));
        if (r.exp_flush) begin
            check("era_out", era_out, r.pc0);
            check("ecode_out", 32'(ecode_out), 32'(r.exc_valid ? r.ecode : exc_int));
            check("redirect_pc", redirect_pc, r.exp_refill ? tlbrentry_addr : eentry_addr);
        end
        if (r.exp_badv) begin
            check("badv_out", badv_out, r.badv);
        end
        if (r.exp_vppn) begin
            check("vppn_out", 32'(vppn_out), 32'(r.badv[31:13]));
        end
        drive_idle();
        // regfile still holds the old values until the next edge
        read_back(r.rd0);
        read_back(r.rd1);
        // lane 1 last so it wins on a shared rd
        if (we0) begin
            model_regs[r.rd0] = d0;
            known[r.rd0]      = 1'b1;
        end
        if (we1) begin
            model_regs[r.rd1] = d1;
            known[r.rd1]      = 1'b1;
        end
        // edge N+1, register file write and flush clear
        @(posedge clk);
        #1;
        if (r.exp_flush) begin
            check("trace_valid", 32'(trace_valid), 32'(1'b0));
            check("trace0_inst", trace0_inst, inst_nop);
            check("trace1_inst", trace1_inst, inst_nop);
            check("trace0_we", 32'(trace0_we), 32'(1'b0));
            check("flush", 32'(flush), 32'(1'b0));
        end
        read_back(r.rd0);
        read_back(r.rd1);
    endtask

    initial begin
        void'($urandom(49106));
        checks    = 0;
        errors    = 0;
        clk       = 1'b0;
        aresetn   = 1'b0;
        raddr     = '0;
        eentry    = eentry_addr;
        tlbrentry = tlbrentry_addr;
        drive_idle();
        for (int k = 0; k < 32; k++) begin
            model_regs[k] = '0;
            known[k]      = (k == 0);
        end
        build_table();
        repeat (4) @(posedge clk);
        #1;
        aresetn = 1'b1;
        // everything quiet out of reset
        check("flush", 32'(flush), 32'(1'b0));
        check("wen_era", 32'(wen_era), 32'(1'b0));
        check("wen_badv", 32'(wen_badv), 32'(1'b0));
        check("wen_vppn", 32'(wen_vppn), 32'(1'b0));
        check("tlb_refill", 32'(tlb_refill), 32'(1'b0));
        check("trace_valid", 32'(trace_valid), 32'(1'b0));
        check("trace0_we", 32'(trace0_we), 32'(1'b0));
        check("trace1_we", 32'(trace1_we), 32'(1'b0));
        for (int i = 0; i < rows.size(); i++) begin
            run_row(rows[i]);
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // hard stop if the run hangs
    initial begin
        #20000;
        $display("timeout: simulation ran past its time limit");
        $display("checks: %0d, errors: %0d", checks, errors + 1);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule
